// ==== alu.sv ====
`timescale 1ns/1ps
`include "datapath_defines.svh"

module alu
    import datapath_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output z_pair_t result
);

    localparam int W       = `WORD_WIDTH;
    localparam int SHAMT_W = $clog2(`WORD_WIDTH);

    logic [SHAMT_W-1:0]      shamt;
    logic signed [W-1:0]     a_s;
    logic signed [W-1:0]     b_s;
    logic signed [2*W-1:0]   product;
    logic [2*W-1:0]          ror_wide;
    logic [2*W-1:0]          rol_wide;
    word_t                   quotient;
    word_t                   remainder;

    assign shamt = b[SHAMT_W-1:0];
    assign a_s   = a;
    assign b_s   = b;

    // Signed 64-bit product
    assign product = a_s * b_s;

    // Rotates by shifting a doubled word
    assign ror_wide = {a, a} >> shamt;
    assign rol_wide = {a, a} << shamt;

    // Division by zero leaves both halves zero
    always_comb begin
        if (b == '0) begin
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = a_s / b_s;
            remainder = a_s % b_s;
        end
    end

    always_comb begin
        result = '0;
        case (op)
            add:    result.lo = a + b;
            sub:    result.lo = a - b;
            and_op: result.lo = a & b;
            or_op:  result.lo = a | b;
            shr:    result.lo = a >> shamt;
            shra:   result.lo = a_s >>> shamt;
            shl:    result.lo = a << shamt;
            ror:    result.lo = ror_wide[W-1:0];
            rol:    result.lo = rol_wide[2*W-1:W];
            mul:    result    = product;
            div: begin
                result.hi = remainder;
                result.lo = quotient;
            end
            // Unary operations act on the bus operand
            neg:    result.lo = -b;
            not_op: result.lo = ~b;
            default: result = '0;
        endcase
    end

endmodule

// ==== bus_mux.sv ====
`timescale 1ns/1ps

module bus_mux
    import datapath_pkg::*;
(
    input  bus_src_t src,
    input  word_t    gpr_data,
    input  word_t    hi,
    input  word_t    lo,
    input  z_pair_t  z,
    input  word_t    pc,
    input  word_t    mdr,
    input  word_t    inport,
    input  word_t    c_sext,
    output word_t    bus
);

    typedef enum logic [3:0] {
        src_none, src_gpr, src_hi, src_lo, src_zhi,
        src_zlo, src_pc, src_mdr, src_inport, src_const
    } bus_sel_e;

    bus_sel_e bus_sel;

    // Priority encoder, constant highest and general register lowest
    always_comb begin
        if (src.c_out)                    bus_sel = src_const;
        else if (src.inport_out)          bus_sel = src_inport;
        else if (src.mdr_out)             bus_sel = src_mdr;
        else if (src.pc_out)              bus_sel = src_pc;
        else if (src.zlo_out)             bus_sel = src_zlo;
        else if (src.zhi_out)             bus_sel = src_zhi;
        else if (src.lo_out)              bus_sel = src_lo;
        else if (src.hi_out)              bus_sel = src_hi;
        else if (src.r_out || src.ba_out) bus_sel = src_gpr;
        else                              bus_sel = src_none;
    end

    always_comb begin
        case (bus_sel)
            src_gpr:    bus = gpr_data;
            src_hi:     bus = hi;
            src_lo:     bus = lo;
            src_zhi:    bus = z.hi;
            src_zlo:    bus = z.lo;
            src_pc:     bus = pc;
            src_mdr:    bus = mdr;
            src_inport: bus = inport;
            src_const:  bus = c_sext;
            default:    bus = '0;
        endcase
    end

endmodule

// ==== bus_register.sv ====
`timescale 1ns/1ps

module bus_register
    import datapath_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  payload_t d,
    output payload_t q
);

    // Holds its value unless load is high
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

// ==== datapath_assertions.sv ====
`timescale 1ns/1ps

module datapath_assertions
    import datapath_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input micro_ctrl_t ctrl,
    input word_t       bus,
    input word_t       out_data,
    input word_t       pc
);

    // Out port changes only when loaded
    out_port_holds: assert property (
        @(posedge clk) disable iff (reset) !ctrl.outport_in |=> $stable(out_data)
    ) else $error("out_data changed while outport_in was low");

    pc_cleared: assert property (
        @(posedge clk) reset |=> (pc == '0)
    ) else $error("PC was not zero in the cycle after reset");

    // Undriven bus reads zero
    bus_idle_zero: assert property (
        @(posedge clk) (ctrl.src == '0) |-> (bus == '0)
    ) else $error("bus was not zero with no source strobe set");

endmodule

bind datapath_top datapath_assertions u_assertions (
    .clk, .reset, .ctrl, .bus, .out_data, .pc
);

// ==== datapath_defines.svh ====
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Bus and register word
`define WORD_WIDTH 32

// General registers, selected by 4-bit IR fields
`define NUM_GPR 16
`define GPR_SEL_WIDTH 4

// RAM geometry, addressed by the low bits of MAR
`define RAM_DEPTH 512
`define RAM_ADDR_WIDTH 9

// ALU operation code
`define OPCODE_WIDTH 5

// Immediate constant at the bottom of the IR
`define CONST_WIDTH 19

`endif

// ==== datapath_pkg.sv ====
`include "datapath_defines.svh"

package datapath_pkg;

    // One bus word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // ALU result and Z register layout
    typedef struct packed {
        word_t hi;
        word_t lo;
    } z_pair_t;

    // Codes not listed here give a zero result
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        add    = 5'd0,
        sub    = 5'd1,
        and_op = 5'd2,
        or_op  = 5'd3,
        shr    = 5'd4,
        shra   = 5'd5,
        shl    = 5'd6,
        ror    = 5'd7,
        rol    = 5'd8,
        mul    = 5'd9,
        div    = 5'd10,
        neg    = 5'd11,
        not_op = 5'd12
    } alu_op_e;

    // Bus source strobes
    typedef struct packed {
        logic r_out;
        logic ba_out;
        logic hi_out;
        logic lo_out;
        logic zhi_out;
        logic zlo_out;
        logic pc_out;
        logic mdr_out;
        logic inport_out;
        logic c_out;
    } bus_src_t;

    // Register file controls
    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
        logic r_in;
        logic r_out;
        logic ba_out;
    } reg_sel_t;

    // One cycle's control word
    typedef struct packed {
        bus_src_t src;
        logic     gra;
        logic     grb;
        logic     grc;
        logic     r_in;
        logic     hi_in;
        logic     lo_in;
        logic     y_in;
        logic     z_in;
        logic     ir_in;
        logic     mar_in;
        logic     mdr_in;
        logic     pc_in;
        logic     con_in;
        logic     outport_in;
        logic     read;
        logic     ram_write;
        logic     inc_pc;
        alu_op_e  opcode;
    } micro_ctrl_t;

    // IR layout; the constant is rc followed by low, bits 18 to 0
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]                 op;
        logic [`GPR_SEL_WIDTH-1:0]                ra;
        logic [`GPR_SEL_WIDTH-1:0]                rb;
        logic [`GPR_SEL_WIDTH-1:0]                rc;
        logic [`CONST_WIDTH-`GPR_SEL_WIDTH-1:0]   low;
    } ir_fields_t;

endpackage

// ==== datapath_top.sv ====
`timescale 1ns/1ps

module datapath_top
    import datapath_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  micro_ctrl_t ctrl,
    input  word_t       in_data,
    output word_t       bus,
    output word_t       out_data,
    output logic        con
);

    word_t      y, hi, lo, ir_word, mar, inport, pc, mdr;
    word_t      gpr_data, c_sext;
    ir_fields_t ir;
    z_pair_t    z, alu_result;
    reg_sel_t   reg_sel;

    assign ir = ir_fields_t'(ir_word);

    // Register file view of the control word
    assign reg_sel = '{
        gra:    ctrl.gra,
        grb:    ctrl.grb,
        grc:    ctrl.grc,
        r_in:   ctrl.r_in,
        r_out:  ctrl.src.r_out,
        ba_out: ctrl.src.ba_out
    };

    bus_register u_y   (.clk, .reset, .load(ctrl.y_in),   .d(bus), .q(y));
    bus_register u_hi  (.clk, .reset, .load(ctrl.hi_in),  .d(bus), .q(hi));
    bus_register u_lo  (.clk, .reset, .load(ctrl.lo_in),  .d(bus), .q(lo));
    bus_register u_ir  (.clk, .reset, .load(ctrl.ir_in),  .d(bus), .q(ir_word));
    bus_register u_mar (.clk, .reset, .load(ctrl.mar_in), .d(bus), .q(mar));

    // In port samples every cycle
    bus_register u_in_port  (.clk, .reset, .load(1'b1), .d(in_data), .q(inport));
    bus_register u_out_port (.clk, .reset, .load(ctrl.outport_in), .d(bus), .q(out_data));

    bus_register #(.payload_t(z_pair_t)) u_z (
        .clk, .reset, .load(ctrl.z_in), .d(alu_result), .q(z)
    );

    register_file u_register_file (
        .clk, .reset, .sel(reg_sel), .ir, .bus, .gpr_data, .c_sext
    );

    bus_mux u_bus_mux (
        .src(ctrl.src), .gpr_data, .hi, .lo, .z, .pc, .mdr, .inport, .c_sext, .bus
    );

    alu u_alu (.op(ctrl.opcode), .a(y), .b(bus), .result(alu_result));

    memory_unit u_memory_unit (
        .clk, .reset, .mdr_in(ctrl.mdr_in), .read(ctrl.read),
        .ram_write(ctrl.ram_write), .bus, .address(mar), .mdr
    );

    // Branch condition sits in rb's low two bits
    program_control u_program_control (
        .clk, .reset, .pc_in(ctrl.pc_in), .inc_pc(ctrl.inc_pc),
        .con_in(ctrl.con_in), .bus, .cond(ir.rb[1:0]), .pc, .con
    );

endmodule

// ==== memory_unit.sv ====
`timescale 1ns/1ps
`include "datapath_defines.svh"

module memory_unit
    import datapath_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  mdr_in,
    input  logic  read,
    input  logic  ram_write,
    input  word_t bus,
    input  word_t address,
    output word_t mdr
);

    word_t                       ram [`RAM_DEPTH];
    logic [`RAM_ADDR_WIDTH-1:0]  ram_addr;
    word_t                       ram_rdata;

    assign ram_addr = address[`RAM_ADDR_WIDTH-1:0];

    // Asynchronous read so MDR can take it in the same cycle
    assign ram_rdata = ram[ram_addr];

    // MDR input select, memory on read, bus otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            mdr <= '0;
        end else if (mdr_in) begin
            mdr <= read ? ram_rdata : bus;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[ram_addr] <= mdr;
        end
    end

endmodule

// ==== program_control.sv ====
`timescale 1ns/1ps
`include "datapath_defines.svh"

module program_control
    import datapath_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pc_in,
    input  logic       inc_pc,
    input  logic       con_in,
    input  word_t      bus,
    input  logic [1:0] cond,
    output word_t      pc,
    output logic       con
);

    logic bus_zero;
    logic bus_neg;
    logic cond_met;

    // Bus load wins over increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_in) begin
            pc <= bus;
        end else if (inc_pc) begin
            pc <= pc + 1'b1;
        end
    end

    assign bus_zero = (bus == '0);
    assign bus_neg  = bus[`WORD_WIDTH-1];

    always_comb begin
        case (cond)
            2'b00:   cond_met = bus_zero;
            2'b01:   cond_met = !bus_zero;
            2'b10:   cond_met = !bus_neg && !bus_zero;
            default: cond_met = bus_neg;
        endcase
    end

    // CON flip-flop
    always_ff @(posedge clk) begin
        if (reset) begin
            con <= 1'b0;
        end else if (con_in) begin
            con <= cond_met;
        end
    end

endmodule

// ==== project.f ====
+incdir+.
datapath_pkg.sv
bus_register.sv
register_file.sv
bus_mux.sv
alu.sv
memory_unit.sv
program_control.sv
datapath_top.sv
datapath_assertions.sv
tb_datapath.sv

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "datapath_defines.svh"

module register_file
    import datapath_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_sel_t   sel,
    input  ir_fields_t ir,
    input  word_t      bus,
    output word_t      gpr_data,
    output word_t      c_sext
);

    word_t                      regs [`NUM_GPR];
    logic [`GPR_SEL_WIDTH-1:0]  reg_idx;
    logic                       field_valid;
    logic [`NUM_GPR-1:0]        write_en;
    logic [`CONST_WIDTH-1:0]    const_field;

    // Field select, first asserted wins
    always_comb begin
        field_valid = 1'b1;
        if (sel.gra) begin
            reg_idx = ir.ra;
        end else if (sel.grb) begin
            reg_idx = ir.rb;
        end else if (sel.grc) begin
            reg_idx = ir.rc;
        end else begin
            reg_idx     = '0;
            field_valid = 1'b0;
        end
    end

    // One-hot write decode
    always_comb begin
        write_en = '0;
        if (sel.r_in && field_valid) begin
            write_en[reg_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_GPR; i++) begin
                if (write_en[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // Base-address use of R0 reads as zero
    always_comb begin
        gpr_data = '0;
        if (sel.ba_out && reg_idx == '0) begin
            gpr_data = '0;
        end else if (sel.r_out || sel.ba_out) begin
            gpr_data = regs[reg_idx];
        end
    end

    // Sign-extended 19-bit constant
    assign const_field = {ir.rc, ir.low};
    assign c_sext = {{(`WORD_WIDTH-`CONST_WIDTH){const_field[`CONST_WIDTH-1]}}, const_field};

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath -f project.f

status=0
./obj_dir/Vtb_datapath > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tb_datapath.sv ====
`timescale 1ns/1ps
`include "datapath_defines.svh"

module tb_datapath
    import datapath_pkg::*;
();

    typedef enum logic [1:0] {chk_none, chk_bus, chk_out, chk_con} check_e;

    typedef struct packed {
        micro_ctrl_t ctrl;
        word_t       in_data;
        check_e      check;
        word_t       expected;
        int          test_id;
    } row_t;

    // Control word bits, in micro_ctrl_t order from the top; opcode sits in 4:0
    localparam logic [31:0] r_out      = 32'h8000_0000;
    localparam logic [31:0] ba_out     = 32'h4000_0000;
    localparam logic [31:0] hi_out     = 32'h2000_0000;
    localparam logic [31:0] lo_out     = 32'h1000_0000;
    localparam logic [31:0] zhi_out    = 32'h0800_0000;
    localparam logic [31:0] zlo_out    = 32'h0400_0000;
    localparam logic [31:0] pc_out     = 32'h0200_0000;
    localparam logic [31:0] mdr_out    = 32'h0100_0000;
    localparam logic [31:0] inport_out = 32'h0080_0000;
    localparam logic [31:0] c_out      = 32'h0040_0000;
    localparam logic [31:0] gra        = 32'h0020_0000;
    localparam logic [31:0] grb        = 32'h0010_0000;
    localparam logic [31:0] grc        = 32'h0008_0000;
    localparam logic [31:0] r_in       = 32'h0004_0000;
    localparam logic [31:0] hi_in      = 32'h0002_0000;
    localparam logic [31:0] lo_in      = 32'h0001_0000;
    localparam logic [31:0] y_in       = 32'h0000_8000;
    localparam logic [31:0] z_in       = 32'h0000_4000;
    localparam logic [31:0] ir_in      = 32'h0000_2000;
    localparam logic [31:0] mar_in     = 32'h0000_1000;
    localparam logic [31:0] mdr_in     = 32'h0000_0800;
    localparam logic [31:0] pc_in      = 32'h0000_0400;
    localparam logic [31:0] con_in     = 32'h0000_0200;
    localparam logic [31:0] outport_in = 32'h0000_0100;
    localparam logic [31:0] read       = 32'h0000_0080;
    localparam logic [31:0] ram_write  = 32'h0000_0040;
    localparam logic [31:0] inc_pc     = 32'h0000_0020;

    logic        clk;
    logic        reset;
    micro_ctrl_t ctrl;
    word_t       in_data;
    word_t       bus;
    word_t       out_data;
    logic        con;

    row_t  rows[$];
    string test_names[$];
    word_t ir_now;
    int    checks = 0;
    int    errors = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    int    cycles = 0;
    int    timeout_limit = 100000;

    datapath_top dut (.clk, .reset, .ctrl, .in_data, .bus, .out_data, .con);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout: run still going after %0d cycles", timeout_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic word_t encode_ir(input logic [4:0] op, input logic [3:0] ra,
                                        input logic [3:0] rb, input logic [18:0] k);
        return {op, ra, rb, k};
    endfunction

    function automatic word_t sign_extend_const(input word_t ir_word);
        return {{13{ir_word[18]}}, ir_word[18:0]};
    endfunction

    // Reference ALU, 64-bit arithmetic on sign-extended operands
    function automatic z_pair_t alu_model(input alu_op_e op, input word_t y, input word_t b);
        longint  sy;
        longint  sb;
        int      s;
        z_pair_t r;
        sy = longint'($signed(y));
        sb = longint'($signed(b));
        s = int'(b[4:0]);
        r = '0;
        case (op)
            add:    r.lo = y + b;
            sub:    r.lo = y - b;
            and_op: r.lo = y & b;
            or_op:  r.lo = y | b;
            shr:    r.lo = y >> s;
            shra:   r.lo = word_t'(sy >>> s);
            shl:    r.lo = y << s;
            ror:    r.lo = (y >> s) | (y << (32 - s));
            rol:    r.lo = (y << s) | (y >> (32 - s));
            mul:    r = sy * sb;
            div: begin
                if (b != '0) begin
                    r.lo = word_t'(sy / sb);
                    r.hi = word_t'(sy % sb);
                end
            end
            neg:    r.lo = 32'd0 - b;
            not_op: r.lo = ~b;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic con_model(input logic [1:0] cond, input word_t v);
        case (cond)
            2'b00:   return v == '0;
            2'b01:   return v != '0;
            2'b10:   return !v[31] && v != '0;
            default: return v[31];
        endcase
    endfunction

    task automatic start_test(input string name);
        test_names.push_back(name);
    endtask

    task automatic add_row(input logic [31:0] c, input word_t d, input check_e k,
                           input word_t e);
        row_t r;
        r.ctrl = c;
        r.in_data = d;
        r.check = k;
        r.expected = e;
        r.test_id = test_names.size() - 1;
        rows.push_back(r);
    endtask

    // In port takes one cycle, then the word goes out on the bus to dst
    task automatic load_word(input word_t d, input logic [31:0] dst);
        add_row('0, d, chk_none, '0);
        add_row(inport_out | dst, d, chk_bus, d);
        if (dst & ir_in) begin
            ir_now = d;
        end
    endtask

    task automatic build_pc_const();
        word_t pv;
        start_test("pc and constant");
        add_row(inc_pc, '0, chk_none, '0);
        add_row(inc_pc, '0, chk_none, '0);
        add_row(pc_out, '0, chk_bus, 32'd2);
        pv = $urandom;
        load_word(pv, pc_in | inc_pc);
        add_row(pc_out, '0, chk_bus, pv);
        load_word(encode_ir(5'd0, 4'd0, 4'd0, 19'h4_5a3c), ir_in);
        add_row(c_out, '0, chk_bus, sign_extend_const(ir_now));
    endtask

    task automatic build_transfer();
        word_t d1;
        word_t d2;
        start_test("register transfer");
        d1 = $urandom;
        d2 = $urandom | 32'd1;
        // ra = rb = 5, rc = 0
        load_word(encode_ir(5'd0, 4'd5, 4'd5, 19'h0_1234), ir_in);
        load_word(d1, gra | r_in);
        add_row(r_out | grb | outport_in, '0, chk_bus, d1);
        add_row('0, '0, chk_out, d1);
        load_word(d2, grc | r_in);
        add_row(r_out | grc, '0, chk_bus, d2);
        add_row(ba_out | grc, '0, chk_bus, '0);
        add_row(ba_out | gra, '0, chk_bus, d1);
    endtask

    task automatic build_priority();
        word_t   h;
        word_t   l;
        word_t   m;
        word_t   p;
        word_t   yv;
        word_t   bv;
        word_t   iv;
        z_pair_t zr;
        start_test("bus priority");
        h = $urandom;
        l = $urandom;
        m = $urandom;
        p = $urandom;
        yv = $urandom;
        bv = $urandom;
        iv = $urandom;
        zr = alu_model(mul, yv, bv);
        load_word(h, hi_in);
        load_word(l, lo_in);
        load_word(m, mdr_in);
        load_word(p, pc_in);
        load_word(yv, y_in);
        load_word(bv, z_in | {27'd0, mul});
        add_row('0, iv, chk_none, '0);
        add_row(hi_out | r_out | gra, iv, chk_bus, h);
        add_row(lo_out | hi_out, iv, chk_bus, l);
        add_row(zhi_out | lo_out, iv, chk_bus, zr.hi);
        add_row(zlo_out | zhi_out, iv, chk_bus, zr.lo);
        add_row(pc_out | zlo_out, iv, chk_bus, p);
        add_row(mdr_out | pc_out, iv, chk_bus, m);
        add_row(inport_out | mdr_out, iv, chk_bus, iv);
        add_row(c_out | inport_out, iv, chk_bus, sign_extend_const(ir_now));
    endtask

    task automatic alu_case(input alu_op_e op, input word_t y, input word_t b);
        z_pair_t r;
        r = alu_model(op, y, b);
        load_word(y, y_in);
        load_word(b, z_in | {27'd0, op});
        add_row(zlo_out, '0, chk_bus, r.lo);
        add_row(zhi_out, '0, chk_bus, r.hi);
    endtask

    task automatic build_alu();
        word_t y;
        word_t b;
        start_test("alu");
        for (int k = 0; k < 13; k++) begin
            y = $urandom;
            b = $urandom;
            if (b == '0) begin
                b = 32'd1;
            end
            alu_case(alu_op_e'(k), y, b);
        end
        alu_case(div, $urandom, '0);
        // Unused opcode gives zero
        alu_case(alu_op_e'(5'd20), $urandom, $urandom);
    endtask

    task automatic build_memory();
        word_t addr;
        word_t w;
        start_test("memory");
        addr = $urandom;
        w = $urandom;
        load_word(addr, mar_in);
        load_word(w, mdr_in);
        add_row(ram_write, '0, chk_none, '0);
        load_word(~w, mdr_in);
        add_row(mdr_out, '0, chk_bus, ~w);
        add_row(mdr_in | read, '0, chk_none, '0);
        add_row(mdr_out, '0, chk_bus, w);
    endtask

    task automatic build_branch();
        logic [1:0] cond;
        word_t      r;
        word_t      sat;
        word_t      fail;
        start_test("branch condition");
        for (int c = 0; c < 4; c++) begin
            cond = c[1:0];
            r = $urandom;
            case (cond)
                2'b00: begin
                    sat = '0;
                    fail = r | 32'd1;
                end
                2'b01: begin
                    sat = r | 32'd1;
                    fail = '0;
                end
                2'b10: begin
                    sat = (r & 32'h7fff_ffff) | 32'd1;
                    fail = r | 32'h8000_0000;
                end
                default: begin
                    sat = r | 32'h8000_0000;
                    fail = r & 32'h7fff_ffff;
                end
            endcase
            load_word(encode_ir(5'd0, 4'd0, {2'b00, cond}, 19'd0), ir_in);
            add_row('0, sat, chk_none, '0);
            add_row(inport_out | con_in, fail, chk_none, '0);
            add_row(inport_out | con_in, fail, chk_con, word_t'(con_model(cond, sat)));
            add_row('0, '0, chk_con, word_t'(con_model(cond, fail)));
        end
    endtask

    task automatic check_row(input row_t r, input int idx);
        word_t actual;
        string name;
        if (r.check != chk_none) begin
            case (r.check)
                chk_bus: begin
                    actual = bus;
                    name = "bus";
                end
                chk_out: begin
                    actual = out_data;
                    name = "out_data";
                end
                default: begin
                    actual = word_t'(con);
                    name = "con";
                end
            endcase
            checks++;
            test_checks++;
            assert (actual === r.expected) else begin
                $display("mismatch %s row %0d: expected %h, got %h",
                         name, idx, r.expected, actual);
                errors++;
                test_errors++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        // Increment held during reset, so reset must win over it
        ctrl = inc_pc;
        in_data = '0;
        void'($urandom(32'h8f18));
        build_pc_const();
        build_transfer();
        build_priority();
        build_alu();
        build_memory();
        build_branch();
        timeout_limit = 16 + rows.size() + 64;

        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            ctrl = rows[i].ctrl;
            in_data = rows[i].in_data;
            // Bus settles well before the rising edge
            #10;
            check_row(rows[i], i);
            if (i == rows.size() - 1 || rows[i + 1].test_id != rows[i].test_id) begin
                $display("test %0d %s: %0d checks, %0d errors", rows[i].test_id,
                         test_names[rows[i].test_id], test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            @(negedge clk);
        end
        ctrl = '0;

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
